// ==== hdl/fetch_mem_if.sv ====
`timescale 1ns/10ps
`default_nettype none

interface fetch_mem_if;

    logic [31:0] addr;         // byte address whose bits 1:0 the memory drops
    logic        cyc;          // request level, one word per cycle it is high
    logic [31:0] instruction;  // read data, valid with ack
    logic        ack;          // one pulse per accepted request

    modport fetch
    (
        output addr,
        output cyc,
        input  instruction,
        input  ack
    );

    modport mem
    (
        input  addr,
        input  cyc,
        output instruction,
        output ack
    );

endinterface

`default_nettype wire

// ==== hdl/rv_fetch.sv ====
`timescale 1ns/10ps
`default_nettype none

module rv_fetch
#(
    parameter logic [31:0] RESET_ADDR = 32'h0000_0000
)
(
    input  wire                i_clk,
    input  wire                i_reset_n,
    input  wire                i_pc_select,
    input  wire         [31:0] i_pc_target,
    input  wire                i_pc_inc,
    fetch_mem_if.fetch         bus,
    output rv_pkg::fetch_bus_t o_bus
);

    localparam int BUF_PARCELS = 8;
    localparam int CNT_BITS    = $clog2(BUF_PARCELS) + 1;

    logic [31:0]                  fetch_pc;
    logic [31:0]                  pc_incr;
    logic                         bus_cyc;
    logic                         issue_next;
    logic                         req_live;
    logic                         req_half;

    logic [BUF_PARCELS-1:0][15:0] parcel_buf;
    logic [BUF_PARCELS-1:0][15:0] parcel_buf_next;
    logic [CNT_BITS-1:0]          buf_cnt;
    logic [CNT_BITS-1:0]          buf_cnt_next;
    logic [CNT_BITS-1:0]          wr_pos;
    logic [31:0]                  head_pc;

    logic                         word_in;
    logic [1:0]                   wr_n;
    logic                         head_comp;
    logic [1:0]                   head_len;
    logic                         head_ready;
    logic                         deliver;
    logic [1:0]                   rd_n;

    // ==================================================================
    // bus side
    // ==================================================================

    assign bus.addr = fetch_pc;
    assign bus.cyc  = bus_cyc;

    // a halfword target only needs the rest of its word
    assign pc_incr = fetch_pc[1] ? 32'd2 : 32'd4;

    // keep room for the word in flight and the next one
    assign issue_next = i_pc_inc &&
        ((int'(buf_cnt_next) + (bus_cyc ? 2 : 0) + 2) <= BUF_PARCELS);

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            fetch_pc <= RESET_ADDR;
            bus_cyc  <= 1'b1;  // first fetch starts right out of reset
            req_live <= 1'b0;
        end
        else if (i_pc_select)
        begin
            fetch_pc <= i_pc_target;
            bus_cyc  <= 1'b1;
            req_live <= 1'b0;  // the word asked for now belongs to the old path
        end
        else
        begin
            if (bus_cyc)
            begin
                fetch_pc <= fetch_pc + pc_incr;
            end
            bus_cyc  <= issue_next;
            req_live <= bus_cyc;
        end
    end

    // ==================================================================
    // parcel buffer
    // ==================================================================

    assign word_in = bus.ack & req_live;
    assign wr_n    = !word_in ? 2'd0 : (req_half ? 2'd1 : 2'd2);

    assign head_comp  = parcel_buf[0][1:0] != rv_pkg::RV32_OPC_DET;
    assign head_len   = head_comp ? 2'd1 : 2'd2;
    assign head_ready = (buf_cnt != '0) && (head_comp || (buf_cnt >= CNT_BITS'(2)));
    assign deliver    = head_ready & i_pc_inc & !i_pc_select;
    assign rd_n       = deliver ? head_len : 2'd0;

    assign wr_pos       = buf_cnt - CNT_BITS'(rd_n);
    assign buf_cnt_next = wr_pos + CNT_BITS'(wr_n);

    // shift out the delivered parcels, then append the new word behind
    always_comb
    begin
        parcel_buf_next = parcel_buf >> (16 * rd_n);
        for (int i = 0; i < BUF_PARCELS; i++)
        begin
            if (word_in && (CNT_BITS'(i) == wr_pos))
            begin
                parcel_buf_next[i] = req_half ? bus.instruction[31:16]
                                              : bus.instruction[15:0];
            end
            else if (word_in && !req_half && (CNT_BITS'(i) == wr_pos + 1'b1))
            begin
                parcel_buf_next[i] = bus.instruction[31:16];
            end
        end
    end

    always_ff @(posedge i_clk)
    begin
        parcel_buf <= parcel_buf_next;
        req_half   <= fetch_pc[1];  // alignment of the request going out now
    end

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            buf_cnt <= '0;
            head_pc <= RESET_ADDR;
        end
        else if (i_pc_select)
        begin
            buf_cnt <= '0;
            head_pc <= i_pc_target;
        end
        else
        begin
            buf_cnt <= buf_cnt_next;
            if (deliver)
            begin
                head_pc <= head_pc + (head_comp ? 32'd2 : 32'd4);
            end
        end
    end

    // ==================================================================
    // delivery
    // ==================================================================

    assign o_bus.pc          = head_pc;
    assign o_bus.instruction = head_comp ? {16'h0000, parcel_buf[0]}
                                         : {parcel_buf[1], parcel_buf[0]};
    assign o_bus.valid       = deliver;

endmodule

`default_nettype wire

// ==== hdl/rv_fetch_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module rv_fetch_top
#(
    parameter logic [31:0] RESET_ADDR     = 32'h0000_0000,
    parameter int          MEM_WORDS_LOG2 = 8
)
(
    input  wire               i_clk,
    input  wire               i_reset_n,
    input  wire               i_pc_select,
    input  wire        [31:0] i_pc_target,
    input  wire               i_pc_inc,
    input  wire               i_mem_we,
    input  wire        [31:0] i_mem_waddr,
    input  wire        [31:0] i_mem_wdata,
    output logic              o_valid,
    output logic       [31:0] o_pc,
    output logic       [31:0] o_instruction,
    output logic              o_compressed,
    output rv_pkg::opclass_e  o_opclass
);

    fetch_mem_if        imem_bus();
    rv_pkg::fetch_bus_t fetch_bus;  // fetch unit to predecode

    rv_fetch #(.RESET_ADDR(RESET_ADDR)) u_fetch (
        .i_clk       (i_clk),
        .i_reset_n   (i_reset_n),
        .i_pc_select (i_pc_select),
        .i_pc_target (i_pc_target),
        .i_pc_inc    (i_pc_inc),
        .bus         (imem_bus.fetch),
        .o_bus       (fetch_bus)
    );

    rv_instr_mem #(.MEM_WORDS_LOG2(MEM_WORDS_LOG2)) u_instr_mem (
        .i_clk     (i_clk),
        .i_reset_n (i_reset_n),
        .bus       (imem_bus.mem),
        .i_we      (i_mem_we),
        .i_waddr   (i_mem_waddr),
        .i_wdata   (i_mem_wdata)
    );

    rv_predecode u_predecode (
        .i_clk         (i_clk),
        .i_reset_n     (i_reset_n),
        .i_bus         (fetch_bus),
        .o_valid       (o_valid),
        .o_pc          (o_pc),
        .o_instruction (o_instruction),
        .o_compressed  (o_compressed),
        .o_opclass     (o_opclass)
    );

endmodule

`default_nettype wire

// ==== hdl/rv_instr_mem.sv ====
`timescale 1ns/10ps
`default_nettype none

module rv_instr_mem
#(
    parameter int MEM_WORDS_LOG2 = 8
)
(
    input  wire        i_clk,
    input  wire        i_reset_n,
    fetch_mem_if.mem   bus,
    input  wire        i_we,
    input  wire [31:0] i_waddr,
    input  wire [31:0] i_wdata
);

    localparam int MEM_WORDS = 2 ** MEM_WORDS_LOG2;

    logic [31:0]               mem [MEM_WORDS];
    logic [MEM_WORDS_LOG2-1:0] rd_index;
    logic [MEM_WORDS_LOG2-1:0] wr_index;

    // word index from a byte address
    assign rd_index = bus.addr[MEM_WORDS_LOG2+1:2];
    assign wr_index = i_waddr[MEM_WORDS_LOG2+1:2];

    // ==================================================================
    // storage and registered read
    // ==================================================================

    always_ff @(posedge i_clk)
    begin
        if (i_we)
        begin
            mem[wr_index] <= i_wdata;  // load port used while the core is idle
        end
        if (bus.cyc)
        begin
            bus.instruction <= mem[rd_index];
        end
    end

    // one acknowledge per sampled request
    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            bus.ack <= 1'b0;
        end
        else
        begin
            bus.ack <= bus.cyc & !i_we;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/rv_pkg.sv ====
`default_nettype none

package rv_pkg;

    // one instruction as handed on by the fetch unit
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] instruction;  // compressed ones sit in the low half
        logic        valid;
    } fetch_bus_t;

    // major instruction classes seen by the predecode stage
    typedef enum logic [3:0] {
        OPC_LOAD,
        OPC_STORE,
        OPC_BRANCH,
        OPC_JAL,
        OPC_JALR,
        OPC_OP,
        OPC_OP_IMM,
        OPC_LUI,
        OPC_AUIPC,
        OPC_SYSTEM,
        OPC_COMPRESSED,
        OPC_OTHER
    } opclass_e;

    // low two bits of every full-size instruction
    localparam logic [1:0] RV32_OPC_DET = 2'b11;

    // major opcodes found in bits 6:2 of a full-size instruction
    typedef enum logic [4:0] {
        RV32_OPC_LOAD   = 5'b00000,
        RV32_OPC_OP_IMM = 5'b00100,
        RV32_OPC_AUIPC  = 5'b00101,
        RV32_OPC_STORE  = 5'b01000,
        RV32_OPC_OP     = 5'b01100,
        RV32_OPC_LUI    = 5'b01101,
        RV32_OPC_BRANCH = 5'b11000,
        RV32_OPC_JALR   = 5'b11001,
        RV32_OPC_JAL    = 5'b11011,
        RV32_OPC_SYSTEM = 5'b11100
    } rv32_opcode_e;

endpackage

`default_nettype wire

// ==== hdl/rv_predecode.sv ====
`timescale 1ns/10ps
`default_nettype none

module rv_predecode
(
    input  wire                       i_clk,
    input  wire                       i_reset_n,
    input  wire rv_pkg::fetch_bus_t   i_bus,
    output logic                      o_valid,
    output logic [31:0]               o_pc,
    output logic [31:0]               o_instruction,
    output logic                      o_compressed,
    output rv_pkg::opclass_e          o_opclass
);

    logic             is_comp;
    rv_pkg::opclass_e opclass;

    assign is_comp = i_bus.instruction[1:0] != rv_pkg::RV32_OPC_DET;

    always_comb
    begin
        if (is_comp)
            opclass = rv_pkg::OPC_COMPRESSED;
        else
        begin
            case (i_bus.instruction[6:2])
                rv_pkg::RV32_OPC_LOAD:   opclass = rv_pkg::OPC_LOAD;
                rv_pkg::RV32_OPC_STORE:  opclass = rv_pkg::OPC_STORE;
                rv_pkg::RV32_OPC_BRANCH: opclass = rv_pkg::OPC_BRANCH;
                rv_pkg::RV32_OPC_JAL:    opclass = rv_pkg::OPC_JAL;
                rv_pkg::RV32_OPC_JALR:   opclass = rv_pkg::OPC_JALR;
                rv_pkg::RV32_OPC_OP:     opclass = rv_pkg::OPC_OP;
                rv_pkg::RV32_OPC_OP_IMM: opclass = rv_pkg::OPC_OP_IMM;
                rv_pkg::RV32_OPC_LUI:    opclass = rv_pkg::OPC_LUI;
                rv_pkg::RV32_OPC_AUIPC:  opclass = rv_pkg::OPC_AUIPC;
                rv_pkg::RV32_OPC_SYSTEM: opclass = rv_pkg::OPC_SYSTEM;
                default:                 opclass = rv_pkg::OPC_OTHER;  // fence, amo and the like
            endcase
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
            o_valid <= 1'b0;
        else
            o_valid <= i_bus.valid;
    end

    // payload only moves with a delivery and holds otherwise
    always_ff @(posedge i_clk)
    begin
        if (i_bus.valid)
        begin
            o_pc          <= i_bus.pc;
            o_instruction <= i_bus.instruction;
            o_compressed  <= is_comp;
            o_opclass     <= opclass;
        end
    end

endmodule

`default_nettype wire

// ==== rv_fetch_top.f ====
hdl/rv_pkg.sv
hdl/fetch_mem_if.sv
hdl/rv_fetch.sv
hdl/rv_instr_mem.sv
hdl/rv_predecode.sv
hdl/rv_fetch_top.sv
sim/tb_rv_fetch_top.sv

// ==== sim/tb_rv_fetch_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_rv_fetch_top;

    localparam logic [31:0] RESET_ADDR     = 32'h0000_0000;
    localparam int          MEM_WORDS_LOG2 = 8;
    localparam int          HALVES         = 2 * (2 ** MEM_WORDS_LOG2);
    localparam int          TEST_LIMIT     = 300;
    localparam int          TOTAL_LIMIT    = 6 * TEST_LIMIT;  // six tests in the sequence

    logic             i_clk = 1'b0;
    logic             i_reset_n;
    logic             i_pc_select;
    logic [31:0]      i_pc_target;
    logic             i_pc_inc;
    logic             i_mem_we;
    logic [31:0]      i_mem_waddr;
    logic [31:0]      i_mem_wdata;
    logic             o_valid;
    logic [31:0]      o_pc;
    logic [31:0]      o_instruction;
    logic             o_compressed;
    rv_pkg::opclass_e o_opclass;

    logic [15:0]      halves [HALVES];
    logic             starts [HALVES] = '{default: 1'b0};
    logic [15:0]      seen = '0;
    logic [31:0]      ref_pc = RESET_ADDR;
    integer           seed = 74781;
    string            test_name = "none";
    int               test_num = 0;
    int               counted_test = 0;
    int               test_cycles = 0;
    int               total_cycles = 0;
    int               delivered = 0;
    int               errors = 0;
    int               err_base = 0;
    int               passes = 0;
    int               fails = 0;

    // major opcodes and their classes where misc-mem stands for the unnamed ones
    logic [4:0] op_codes [11] = '{5'b00000, 5'b01000, 5'b11000, 5'b11011, 5'b11001,
                                  5'b01100, 5'b00100, 5'b01101, 5'b00101, 5'b11100, 5'b00011};
    rv_pkg::opclass_e op_classes [11] = '{rv_pkg::OPC_LOAD, rv_pkg::OPC_STORE,
        rv_pkg::OPC_BRANCH, rv_pkg::OPC_JAL, rv_pkg::OPC_JALR, rv_pkg::OPC_OP,
        rv_pkg::OPC_OP_IMM, rv_pkg::OPC_LUI, rv_pkg::OPC_AUIPC, rv_pkg::OPC_SYSTEM,
        rv_pkg::OPC_OTHER};

    rv_fetch_top #(.RESET_ADDR(RESET_ADDR), .MEM_WORDS_LOG2(MEM_WORDS_LOG2)) UUT (.*);

    always #2 i_clk = ~i_clk;

    // =====================================================================
    // program image and reference model
    // =====================================================================

    // the first 128 bytes hold only full-size instructions and the rest mix C C F C F C
    task automatic build_image();
        int          k;
        int          h;
        logic [31:0] w;
        k = 0;
        h = 0;
        while (h < HALVES)
        begin
            w         = $random(seed);
            starts[h] = 1'b1;
            if (h < 64 || ((k % 6 == 3 || k % 6 == 5) && h < HALVES - 1))
            begin
                w[6:0]        = {op_codes[k % 11], 2'b11};
                halves[h]     = w[15:0];
                halves[h + 1] = w[31:16];
                h += 2;
            end
            else
            begin
                if (w[1:0] == 2'b11)
                    w[1:0] = 2'b01;
                halves[h] = w[15:0];
                h += 1;
            end
            k++;
        end
    endtask

    function automatic logic [31:0] find_start(input int from, input int odd);
        int h;
        h = from;
        while (!starts[h] || (h % 2) != odd)
            h++;
        return 32'(h * 2);
    endfunction

    // reads the halfword at pc and joins the next one for a full-size instruction
    function automatic logic [31:0] ref_next(input logic [31:0] pc, output logic [31:0] instr,
                                             output rv_pkg::opclass_e cls);
        logic [15:0] lo;
        logic [15:0] hi;
        lo  = halves[(pc / 2) % HALVES];
        hi  = halves[(pc / 2 + 1) % HALVES];
        cls = rv_pkg::OPC_OTHER;
        if (lo[1:0] != 2'b11)
        begin
            instr = {16'h0000, lo};
            cls   = rv_pkg::OPC_COMPRESSED;
            return pc + 32'd2;
        end
        instr = {hi, lo};
        for (int i = 0; i < 11; i++)
            if (op_codes[i] == lo[6:2])
                cls = op_classes[i];
        return pc + 32'd4;
    endfunction

    task automatic check_fetch(input logic [31:0] exp_pc, input logic [31:0] exp_instr,
                               input logic [31:0] act_pc, input logic [31:0] act_instr);
        if (act_pc !== exp_pc || act_instr !== exp_instr)
        begin
            $display("[ERROR] %s: expected pc %h instr %h, actual pc %h instr %h",
                     test_name, exp_pc, exp_instr, act_pc, act_instr);
            errors++;
        end
    endtask

    task automatic check_class(input rv_pkg::opclass_e exp_cls, input logic exp_comp,
                               input rv_pkg::opclass_e act_cls, input logic act_comp);
        if (act_cls !== exp_cls || act_comp !== exp_comp)
        begin
            $display("[ERROR] %s: expected class %s compressed %b, actual class %s compressed %b",
                     test_name, exp_cls.name(), exp_comp, act_cls.name(), act_comp);
            errors++;
        end
    endtask

    always @(posedge i_clk)
    begin : compare
        logic [31:0]      exp_instr;
        logic [31:0]      next_pc;
        rv_pkg::opclass_e exp_cls;
        if (!i_reset_n)
            ref_pc = RESET_ADDR;
        else if (o_valid)
        begin
            next_pc = ref_next(ref_pc, exp_instr, exp_cls);
            check_fetch(ref_pc, exp_instr, o_pc, o_instruction);
            check_class(exp_cls, exp_cls == rv_pkg::OPC_COMPRESSED, o_opclass, o_compressed);
            seen[o_opclass] = 1'b1;
            ref_pc          = next_pc;
            delivered      <= delivered + 1;
        end
        if (i_pc_select)
            ref_pc = i_pc_target;  // the next delivery has to come from the target
    end

    always @(posedge i_clk)
    begin
        if (test_num != counted_test)
        begin
            counted_test = test_num;
            test_cycles  = 0;
        end
        if (test_num != 0)
        begin
            test_cycles++;
            total_cycles++;
        end
        if (test_cycles > TEST_LIMIT || total_cycles > TOTAL_LIMIT)
        begin
            $display("test %s never finished, stopped after %0d cycles", test_name, test_cycles);
            $display("Checks failed");
            $finish;
        end
    end

    // =====================================================================
    // test sequence
    // =====================================================================

    task automatic start_test(input string name);
        @(negedge i_clk);
        test_name = name;
        @(posedge i_clk);
        test_num <= test_num + 1;
    endtask

    task automatic finish_test();
        @(negedge i_clk);
        if (errors == err_base)
        begin
            passes++;
            $display("test %s: ok", test_name);
        end
        else
        begin
            fails++;
            $display("test %s: %0d errors", test_name, errors - err_base);
        end
        err_base = errors;
        @(posedge i_clk);
    endtask

    task automatic redirect(input logic [31:0] target);
        i_pc_select <= 1'b1;
        i_pc_target <= target;
        @(posedge i_clk);
        i_pc_select <= 1'b0;
    endtask

    // waits for a number of deliveries, with random stretches of i_pc_inc low if asked
    task automatic run_deliveries(input int count, input logic stall);
        int goal;
        int stretch;
        goal    = delivered + count;
        stretch = 0;
        while (delivered < goal)
        begin
            if (stall)
            begin
                if (stretch == 0)
                begin
                    stretch   = 1 + ($random(seed) & 7);
                    i_pc_inc <= ($random(seed) % 2) == 0;
                end
                stretch--;
            end
            @(posedge i_clk);
        end
        i_pc_inc <= 1'b1;
    endtask

    initial
    begin
        i_reset_n   = 1'b0;
        i_pc_select = 1'b0;
        i_pc_target = '0;
        i_pc_inc    = 1'b1;
        i_mem_we    = 1'b0;
        i_mem_waddr = '0;
        i_mem_wdata = '0;
        build_image();
        for (int w = 0; w < HALVES / 2; w++)
        begin
            @(posedge i_clk);
            i_mem_we    <= 1'b1;  // the whole memory is written while reset is held
            i_mem_waddr <= 32'(w * 4);
            i_mem_wdata <= {halves[2 * w + 1], halves[2 * w]};
        end
        @(posedge i_clk);
        i_mem_we <= 1'b0;
        repeat (3) @(posedge i_clk);
        i_reset_n <= 1'b1;

        start_test("reset");
        @(negedge i_clk);
        if (o_valid !== 1'b0)
        begin
            $display("reset: o_valid is high before any instruction was fetched");
            errors++;
        end
        run_deliveries(1, 1'b0);
        finish_test();
        start_test("full_size");
        run_deliveries(23, 1'b0);
        finish_test();
        start_test("mixed");
        redirect(32'h0000_0080);
        run_deliveries(40, 1'b0);
        finish_test();
        start_test("redirect");
        redirect(find_start(256, 0));
        run_deliveries(12, 1'b0);
        redirect(find_start(384, 1));
        run_deliveries(12, 1'b0);
        finish_test();
        start_test("stall");
        run_deliveries(40, 1'b1);
        finish_test();
        start_test("opclass");
        redirect(RESET_ADDR);
        run_deliveries(40, 1'b0);
        @(negedge i_clk);
        if (seen[11:0] != 12'hfff)
        begin
            $display("opclass: not every opcode class was delivered");
            errors++;
        end
        finish_test();

        @(negedge i_clk);
        $display("tests passed: %0d, failed: %0d", passes, fails);
        if (fails == 0 && errors == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire
